//--- adc_to_buffer_block.f
src/acq_pkg.sv
src/fill_trigger_decode.sv
src/burst_sequencer.sv
src/sync_fifo.sv
src/burst_buffer.sv
src/adc_to_buffer_block.sv
tb/tb_adc_to_buffer_block.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and judge the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_to_buffer_block \
	-f adc_to_buffer_block.f > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_adc_to_buffer_block > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "test failed, see sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "test passed"
exit 0

//--- src/acq_pkg.sv
package acq_pkg;

	//////////////////////////////////////////////////
	// widths shared by the acquisition path

	localparam int ADC_W             = 12;	// raw adc sample bits
	localparam int SAMPLE_W          = 16;	// one sample slot in a burst
	localparam int SAMPLES_PER_BURST = 8;	// slots per 128-bit burst
	localparam int BURST_W           = SAMPLE_W * SAMPLES_PER_BURST;	// 128
	localparam int BURST_CNT_W       = 21;	// bursts per fill
	localparam int FILL_NUM_W        = 24;	// fill (event) number
	localparam int ADDR_W            = 23;	// burst address as seen outside
	localparam int CHAN_TAG_W        = 16;	// channel info carried in the header
	localparam int HDR_PAD_W         = 42;	// unused top bits of the header

	//////////////////////////////////////////////////
	// fill type, value is {acq_enable1, acq_enable0}

	typedef enum logic [1:0] {
		FILL_NONE  = 2'b00,	// acquisition disabled
		FILL_MUON  = 2'b01,	// muon fill
		FILL_LASER = 2'b10,	// laser calibration fill
		FILL_PED   = 2'b11	// pedestal fill
	} fill_type_e;

	//////////////////////////////////////////////////
	// bundles passed between blocks

	// decode -> sequencer, 47 bits
	typedef struct packed {
		fill_type_e               fill_type;	// what kind of fill
		logic [BURST_CNT_W-1:0]   num_bursts;	// bursts to record
		logic [FILL_NUM_W-1:0]    fill_num;	// number given to this fill
	} fill_cmd_t;

	// one burst on its way to the burst memory, 152 bits
	typedef struct packed {
		logic [BURST_W-1:0]       data;	// 8 packed sample slots
		logic [ADDR_W-1:0]        addr;	// burst address
		logic                     last;	// final burst of the fill
	} acq_word_t;

	// header word, 128 bits, lsb end is start_addr
	typedef struct packed {
		logic [HDR_PAD_W-1:0]     pad;	// zero
		logic [FILL_NUM_W-1:0]    fill_num;	// fill number
		fill_type_e               fill_type;	// muon / laser / pedestal
		logic [CHAN_TAG_W-1:0]    channel_tag;	// copied from the input port
		logic [BURST_CNT_W-1:0]   num_bursts;	// bursts that follow
		logic [ADDR_W-1:0]        start_addr;	// address of the first burst
	} fill_header_t;

endpackage

//--- src/adc_to_buffer_block.sv
module adc_to_buffer_block #(
	parameter int MEM_AW     = 6,	// burst memory holds 2**MEM_AW bursts
	parameter int WORD_DEPTH = 4,	// word queue entries
	parameter int HDR_DEPTH  = 4	// header queue entries
) (
	input  logic                            clk125,	// system clock
	input  logic                            arst_n,	// async reset, active low
	input  logic                            acq_reset,	// reset the acquisition logic
	input  logic [acq_pkg::CHAN_TAG_W-1:0]  channel_tag,	// put in every header
	input  logic [acq_pkg::BURST_CNT_W-1:0] num_muon_bursts,	// bursts in a muon fill
	input  logic [acq_pkg::BURST_CNT_W-1:0] num_laser_bursts,	// bursts in a laser fill
	input  logic [acq_pkg::BURST_CNT_W-1:0] num_ped_bursts,	// bursts in a pedestal fill
	input  logic [acq_pkg::FILL_NUM_W-1:0]  initial_fill_num,	// first fill number
	input  logic                            initial_fill_num_wr,	// load strobe
	input  logic                            acq_enable0,	// enable / fill type bit 0
	input  logic                            acq_enable1,	// enable / fill type bit 1
	input  logic                            acq_trig,	// start a fill
	input  logic [acq_pkg::ADC_W-1:0]       adc_data,	// adc sample
	input  logic                            adc_ovr,	// adc over-range
	input  logic                            fill_header_fifo_rd_en,	// pop a header
	input  logic [acq_pkg::ADDR_W-1:0]      ddr3_rd_burst_addr,	// burst to read
	input  logic                            ddr3_rd_one_burst,	// read strobe
	output logic                            acq_enabled,	// ready for a trigger
	output logic [acq_pkg::FILL_NUM_W-1:0]  fill_num,	// next fill number
	output logic                            acq_done,	// fill fully in memory
	output logic                            fill_header_fifo_empty,	// no header waiting
	output logic [acq_pkg::BURST_W-1:0]     fill_header_fifo_out,	// head header
	output logic                            ddr3_one_burst_rdy,	// read data valid
	output logic [acq_pkg::BURST_W-1:0]     ddr3_one_burst_data	// read data
);
	import acq_pkg::*;

	fill_cmd_t    cmd;	// decode -> sequencer
	logic         cmd_valid;
	logic         busy;	// sequencer -> decode
	acq_word_t    seq_word;	// burst into the word queue
	logic         word_push;
	fill_header_t seq_header;	// header into the header queue
	logic         header_push;
	acq_word_t    buf_word;	// head of the word queue
	logic         word_empty;
	logic         word_pop;

	//////////////////////////////////////////////////
	// decode

	fill_trigger_decode u_decode (
		.clk125, .arst_n, .acq_reset,
		.acq_enable0, .acq_enable1, .acq_trig,
		.num_muon_bursts, .num_laser_bursts, .num_ped_bursts,
		.initial_fill_num, .initial_fill_num_wr,
		.busy, .acq_enabled, .fill_num,
		.cmd, .cmd_valid
	);

	//////////////////////////////////////////////////
	// execute

	burst_sequencer #(.MEM_AW(MEM_AW)) u_sequencer (
		.clk125, .arst_n, .acq_reset,
		.cmd, .cmd_valid, .channel_tag, .adc_data, .adc_ovr,
		.busy,
		.word(seq_word), .word_push,
		.header(seq_header), .header_push
	);

	//////////////////////////////////////////////////
	// queues and result

	sync_fifo #(.payload_t(acq_word_t), .DEPTH(WORD_DEPTH)) u_word_fifo (
		.clk125, .arst_n, .clr(acq_reset),
		.push(word_push), .din(seq_word),
		.pop(word_pop), .dout(buf_word),
		.empty(word_empty), .full()	// drained faster than filled
	);

	sync_fifo #(.payload_t(fill_header_t), .DEPTH(HDR_DEPTH)) u_header_fifo (
		.clk125, .arst_n, .clr(acq_reset),
		.push(header_push), .din(seq_header),
		.pop(fill_header_fifo_rd_en), .dout(fill_header_fifo_out),
		.empty(fill_header_fifo_empty), .full()
	);

	burst_buffer #(.MEM_AW(MEM_AW)) u_buffer (
		.clk125, .arst_n,
		.word(buf_word), .word_empty,
		.rd_one_burst(ddr3_rd_one_burst), .rd_burst_addr(ddr3_rd_burst_addr),
		.word_pop,
		.one_burst_rdy(ddr3_one_burst_rdy), .one_burst_data(ddr3_one_burst_data),
		.acq_done
	);

endmodule

//--- src/burst_buffer.sv
module burst_buffer #(
	parameter int MEM_AW = 6	// burst memory address bits
) (
	input  logic                        clk125,	// system clock
	input  logic                        arst_n,	// async reset, active low
	input  acq_pkg::acq_word_t          word,	// head of the word queue
	input  logic                        word_empty,	// word queue empty
	input  logic                        rd_one_burst,	// burst read strobe
	input  logic [acq_pkg::ADDR_W-1:0]  rd_burst_addr,	// burst to read
	output logic                        word_pop,	// take the head word
	output logic                        one_burst_rdy,	// read data valid, one cycle
	output logic [acq_pkg::BURST_W-1:0] one_burst_data,	// read data
	output logic                        acq_done	// last burst of a fill written
);
	import acq_pkg::*;

	localparam int MEM_DEPTH = 2 ** MEM_AW;	// bursts held

	logic [BURST_W-1:0] mem [MEM_DEPTH];	// single-port burst memory
	logic [MEM_AW-1:0]  port_addr;	// shared address of the one port
	logic               port_we;	// write this edge

	//////////////////////////////////////////////////
	// port arbitration, a read request always wins and
	// the word waits in the queue for a free cycle

	assign word_pop  = !word_empty && !rd_one_burst;
	assign port_we   = word_pop;	// popped word is written on the same edge
	assign port_addr = rd_one_burst ? rd_burst_addr[MEM_AW-1:0] : word.addr[MEM_AW-1:0];

	// high in the cycle whose closing edge writes the last burst
	assign acq_done = word_pop && word.last;

	//////////////////////////////////////////////////
	// memory, one access per edge

	always_ff @(posedge clk125) begin
		if (port_we)
			mem[port_addr] <= word.data;
		if (rd_one_burst)
			one_burst_data <= mem[port_addr];	// registered read data
	end

	always_ff @(posedge clk125 or negedge arst_n) begin
		if (!arst_n)
			one_burst_rdy <= 1'b0;
		else
			one_burst_rdy <= rd_one_burst;	// one cycle after the request edge
	end

endmodule

//--- src/burst_sequencer.sv
module burst_sequencer #(
	parameter int MEM_AW = 6	// burst memory address bits
) (
	input  logic                           clk125,	// system clock
	input  logic                           arst_n,	// async reset, active low
	input  logic                           acq_reset,	// abandon the fill, address back to 0
	input  acq_pkg::fill_cmd_t             cmd,	// fill command
	input  logic                           cmd_valid,	// command strobe
	input  logic [acq_pkg::CHAN_TAG_W-1:0] channel_tag,	// goes into the header
	input  logic [acq_pkg::ADC_W-1:0]      adc_data,	// adc sample
	input  logic                           adc_ovr,	// adc over-range
	output logic                           busy,	// fill in progress
	output acq_pkg::acq_word_t             word,	// completed burst
	output logic                           word_push,	// word queue push
	output acq_pkg::fill_header_t          header,	// header of the fill
	output logic                           header_push	// header queue push
);
	import acq_pkg::*;

	localparam int SAMP_CW = $clog2(SAMPLES_PER_BURST);	// slot counter bits

	typedef enum logic {
		ST_IDLE,	// waiting for a command
		ST_RUN	// header out, capturing samples
	} seq_state_e;

	seq_state_e             state;
	logic [MEM_AW-1:0]      wr_addr;	// next burst address, wraps
	logic [SAMP_CW-1:0]     samp_cnt;	// slot being filled
	logic [BURST_CNT_W-1:0] burst_cnt;	// bursts done in this fill
	logic [BURST_CNT_W-1:0] num_bursts;	// bursts asked for
	logic [BURST_W-1:0]     acc;	// partly filled burst
	logic [SAMPLE_W-1:0]    slot;	// current sample as a 16-bit slot
	logic                   burst_done;	// 8th sample of a burst this edge
	logic                   last_burst;	// burst being filled is the final one

	assign busy = (state == ST_RUN);

	// 3 zero bits, over-range, 12 data bits
	assign slot = {{(SAMPLE_W - ADC_W - 1){1'b0}}, adc_ovr, adc_data};

	assign burst_done = busy && (samp_cnt == SAMP_CW'(SAMPLES_PER_BURST - 1));
	assign last_burst = (burst_cnt == num_bursts - 1'b1);

	//////////////////////////////////////////////////
	// word output, new sample shifts in at the top so the
	// first sample of a burst ends up in bits 15:0

	assign word.data = {slot, acc[BURST_W-1:SAMPLE_W]};
	assign word.addr = ADDR_W'(wr_addr);	// zero-extended
	assign word.last = last_burst;
	assign word_push = burst_done;	// same edge as the 8th capture

	//////////////////////////////////////////////////
	// control

	always_ff @(posedge clk125 or negedge arst_n) begin
		if (!arst_n) begin
			state       <= ST_IDLE;
			wr_addr     <= '0;
			samp_cnt    <= '0;
			burst_cnt   <= '0;
			header_push <= 1'b0;
		end else if (acq_reset) begin
			state       <= ST_IDLE;
			wr_addr     <= '0;	// next fill starts at burst 0
			samp_cnt    <= '0;
			burst_cnt   <= '0;
			header_push <= 1'b0;
		end else begin
			header_push <= 1'b0;	// one-cycle strobe
			case (state)
				ST_IDLE: begin
					if (cmd_valid) begin
						state       <= ST_RUN;	// busy from here on
						header_push <= 1'b1;	// header lands with the 1st capture
						samp_cnt    <= '0;
						burst_cnt   <= '0;
					end
				end
				ST_RUN: begin
					samp_cnt <= samp_cnt + 1'b1;	// wraps every burst
					if (burst_done) begin
						wr_addr   <= wr_addr + 1'b1;	// modulo memory size
						burst_cnt <= burst_cnt + 1'b1;
						if (last_burst)
							state <= ST_IDLE;	// busy drops with the last push
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// payload, no reset

	always_ff @(posedge clk125) begin
		if (busy)
			acc <= word.data;	// one capture per edge
		if (cmd_valid && !busy) begin
			num_bursts         <= cmd.num_bursts;
			header.pad         <= '0;
			header.fill_num    <= cmd.fill_num;
			header.fill_type   <= cmd.fill_type;
			header.channel_tag <= channel_tag;
			header.num_bursts  <= cmd.num_bursts;
			header.start_addr  <= ADDR_W'(wr_addr);	// first burst of this fill
		end
	end

	// a fill needs a real type and at least one burst, else it never ends
	a_hdr_from_cmd: assert property (@(posedge clk125) disable iff (!arst_n || acq_reset)
		header_push |-> busy && header.fill_type != FILL_NONE && header.num_bursts != '0);
	// every word closes eight captures of a running fill
	a_word_in_fill: assert property (@(posedge clk125) disable iff (!arst_n || acq_reset)
		word_push |-> $past(busy, SAMPLES_PER_BURST - 1));

endmodule

//--- src/fill_trigger_decode.sv
module fill_trigger_decode (
	input  logic                            clk125,	// system clock
	input  logic                            arst_n,	// async reset, active low
	input  logic                            acq_reset,	// clears the acquisition logic
	input  logic                            acq_enable0,	// fill type bit 0
	input  logic                            acq_enable1,	// fill type bit 1
	input  logic                            acq_trig,	// start a fill
	input  logic [acq_pkg::BURST_CNT_W-1:0] num_muon_bursts,	// bursts in a muon fill
	input  logic [acq_pkg::BURST_CNT_W-1:0] num_laser_bursts,	// bursts in a laser fill
	input  logic [acq_pkg::BURST_CNT_W-1:0] num_ped_bursts,	// bursts in a pedestal fill
	input  logic [acq_pkg::FILL_NUM_W-1:0]  initial_fill_num,	// load value for the counter
	input  logic                            initial_fill_num_wr,	// load strobe
	input  logic                            busy,	// sequencer still recording
	output logic                            acq_enabled,	// ready to take a trigger
	output logic [acq_pkg::FILL_NUM_W-1:0]  fill_num,	// number for the next fill
	output acq_pkg::fill_cmd_t              cmd,	// command to the sequencer
	output logic                            cmd_valid	// one-cycle command strobe
);
	import acq_pkg::*;

	fill_type_e             dec_type;	// decoded enables
	logic [BURST_CNT_W-1:0] sel_bursts;	// burst count of dec_type
	logic                   accept;	// trigger taken this edge

	assign dec_type = fill_type_e'({acq_enable1, acq_enable0});

	always_comb begin
		case (dec_type)
			FILL_MUON:  sel_bursts = num_muon_bursts;
			FILL_LASER: sel_bursts = num_laser_bursts;
			FILL_PED:   sel_bursts = num_ped_bursts;
			default:    sel_bursts = '0;	// disabled, never accepted
		endcase
	end

	// cmd_valid blocks a held trigger before busy has risen
	assign accept = acq_trig && !busy && !cmd_valid && (dec_type != FILL_NONE) &&
		(sel_bursts != '0);
	assign acq_enabled = (dec_type != FILL_NONE) && !busy;

	always_ff @(posedge clk125 or negedge arst_n) begin
		if (!arst_n) begin
			cmd_valid <= 1'b0;
		end else if (acq_reset) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= accept;	// strobe in the cycle after the trigger edge
		end
	end

	// fill numbers run on across acq_reset
	always_ff @(posedge clk125 or negedge arst_n) begin
		if (!arst_n) begin
			fill_num <= '0;
		end else if (initial_fill_num_wr) begin
			fill_num <= initial_fill_num;	// load wins over a trigger
		end else if (accept && !acq_reset) begin
			fill_num <= fill_num + 1'b1;	// this fill uses the old value
		end
	end

	always_ff @(posedge clk125) begin
		if (accept) begin
			cmd.fill_type  <= dec_type;
			cmd.num_bursts <= sel_bursts;
			cmd.fill_num   <= fill_num;
		end
	end

	// the sequencer must be idle for every command and take it on the next edge
	a_cmd_idle: assert property (@(posedge clk125) disable iff (!arst_n || acq_reset)
		cmd_valid |-> !busy ##1 busy);

endmodule

//--- src/sync_fifo.sv
module sync_fifo #(
	parameter type payload_t = logic [7:0],	// entry type
	parameter int  DEPTH     = 4	// entries
) (
	input  logic     clk125,	// system clock
	input  logic     arst_n,	// async reset, active low
	input  logic     clr,	// synchronous flush
	input  logic     push,	// write din
	input  payload_t din,	// entry in
	input  logic     pop,	// drop the head entry
	output payload_t dout,	// head entry, valid while !empty
	output logic     empty,	// nothing stored
	output logic     full	// no room
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;	// pointer bits

	payload_t        mem [DEPTH];	// storage, no reset
	logic [PW-1:0]   wr_ptr;	// next free entry
	logic [PW-1:0]   rd_ptr;	// head entry
	logic [PW:0]     count;	// entries held
	logic            do_push;
	logic            do_pop;

	assign empty   = (count == '0);
	assign full    = (count == (PW + 1)'(DEPTH));
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign dout    = mem[rd_ptr];	// show-ahead

	always_ff @(posedge clk125) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk125 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clr) begin
			wr_ptr <= '0;	// stored entries are dropped
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	// users must respect the flags, a lost entry would corrupt a fill
	a_no_overflow: assert property (@(posedge clk125) disable iff (!arst_n || clr)
		push |-> !full);
	a_no_underflow: assert property (@(posedge clk125) disable iff (!arst_n || clr)
		pop |-> !empty);

endmodule

//--- tb/tb_adc_to_buffer_block.sv
module tb_adc_to_buffer_block;

	localparam int          MEM_AW     = 6;
	localparam int          MEM_BURSTS = 2 ** MEM_AW;	// memory size in bursts
	localparam int          HIST_LEN   = 4096;	// ring of driven samples
	localparam int          WAIT_LIMIT = 200;	// cycles before a wait gives up
	localparam logic [15:0] TAG        = 16'hc35a;	// channel tag for every header
	localparam logic [23:0] FIRST_FILL = 24'h00_1230;	// loaded fill number

	logic          clk125 = 1'b0;
	logic          arst_n;
	logic          acq_reset;
	logic [15:0]   channel_tag;
	logic [20:0]   num_muon_bursts, num_laser_bursts, num_ped_bursts;
	logic [23:0]   initial_fill_num;
	logic          initial_fill_num_wr;
	logic          acq_enable0, acq_enable1, acq_trig;
	logic [11:0]   adc_data = '0;	// owned by the sample driver
	logic          adc_ovr = 1'b0;
	logic          fill_header_fifo_rd_en;
	logic [22:0]   ddr3_rd_burst_addr;
	logic          ddr3_rd_one_burst;
	logic          acq_enabled, acq_done, fill_header_fifo_empty, ddr3_one_burst_rdy;
	logic [23:0]   fill_num;
	logic [127:0]  fill_header_fifo_out, ddr3_one_burst_data;

	integer        seed = 32'h3f6a_5271;	// fixed seed for the adc stream
	logic [31:0]   rnd;
	int            edge_cnt = 0;	// rising edges so far
	logic [12:0]   hist [HIST_LEN];	// {ovr, data} driven after each edge
	int            errors = 0;
	int            timeouts = 0;
	logic [127:0]  exp_hdr_q [$];	// headers expected at each pop
	logic [127:0]  exp_rd_q [$];	// bursts expected at each read
	logic          req_prev = 1'b0;	// read strobe one cycle back
	logic [23:0]   exp_fill;	// model of the fill counter
	int            exp_addr;	// model of the next burst address
	int            base1, base2, base3, base4, base5;	// first sample index per fill
	int            sa1, sa2, sa3, sa4, sa5;	// start address per fill

	adc_to_buffer_block #(.MEM_AW(MEM_AW), .WORD_DEPTH(4), .HDR_DEPTH(4)) UUT (.*);

	always #20 clk125 = ~clk125;	// period 40

	always @(posedge clk125)
		edge_cnt <= edge_cnt + 1;

	// new random sample a little after every edge, kept for the model
	always @(posedge clk125) begin
		#1;
		rnd = $random(seed);
		adc_data = rnd[11:0];
		adc_ovr = rnd[12];
		hist[edge_cnt % HIST_LEN] = {rnd[12], rnd[11:0]};
	end

	//////////////////////////////////////////////////
	// reference model

	// header layout: pad 42, fill_num 24, type 2, tag 16, bursts 21, start 23
	function automatic logic [127:0] exp_header(input logic [1:0] ftype, input logic [20:0] nb,
		input logic [23:0] fnum, input logic [22:0] saddr);
		return {42'd0, fnum, ftype, TAG, nb, saddr};
	endfunction

	// 8 slots of {3'b0, ovr, data}, first sample at the bottom
	function automatic logic [127:0] exp_burst(input int first);
		logic [127:0] r;
		for (int i = 0; i < 8; i++)
			r[16*i +: 16] = {3'b000, hist[(first + i) % HIST_LEN]};
		return r;
	endfunction

	function automatic logic [20:0] nb_of(input logic [1:0] ftype);
		case (ftype)
			2'b01:   return num_muon_bursts;
			2'b10:   return num_laser_bursts;
			2'b11:   return num_ped_bursts;
			default: return '0;	// disabled
		endcase
	endfunction

	//////////////////////////////////////////////////
	// compare process, outputs are stable at the falling edge

	always @(negedge clk125) begin : compare
		logic [127:0] want;
		if (arst_n) begin
			assert (ddr3_one_burst_rdy == req_prev) else begin
				errors++;
				$display("Fail ddr3_one_burst_rdy: got %h expected %h",
					ddr3_one_burst_rdy, req_prev);
			end
			if (ddr3_one_burst_rdy) begin
				assert (exp_rd_q.size() > 0) else begin
					errors++;
					$display("read data came back with no read outstanding");
				end
				if (exp_rd_q.size() > 0) begin
					want = exp_rd_q.pop_front();
					assert (ddr3_one_burst_data == want) else begin
						errors++;
						$display("Fail ddr3_one_burst_data: got %h expected %h",
							ddr3_one_burst_data, want);
					end
				end
			end
			if (fill_header_fifo_rd_en && exp_hdr_q.size() > 0) begin
				want = exp_hdr_q.pop_front();
				assert (fill_header_fifo_out == want) else begin
					errors++;
					$display("Fail fill_header_fifo_out: got %h expected %h",
						fill_header_fifo_out, want);
				end
			end
		end
		req_prev = ddr3_rd_one_burst;
	end

	//////////////////////////////////////////////////
	// helpers

	task automatic step();
		@(posedge clk125);
		#1;
	endtask

	task automatic expect_equal(input string name, input logic [127:0] got,
		input logic [127:0] want);
		assert (got == want) else begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		@(negedge clk125);
		while (!acq_done && n < WAIT_LIMIT) begin
			@(negedge clk125);
			n++;
		end
		if (!acq_done) begin
			timeouts++;
			$display("timeout, acq_done never pulsed");
		end
	endtask

	task automatic pop_header(input logic [127:0] hdr);
		int n;
		n = 0;
		@(negedge clk125);
		while (fill_header_fifo_empty && n < WAIT_LIMIT) begin
			@(negedge clk125);
			n++;
		end
		if (fill_header_fifo_empty) begin
			timeouts++;
			$display("timeout, no header arrived in the header queue");
		end else begin
			step();
			exp_hdr_q.push_back(hdr);
			fill_header_fifo_rd_en = 1'b1;
			step();
			fill_header_fifo_rd_en = 1'b0;
		end
	endtask

	// strobe stays high across back-to-back calls
	task automatic read_burst(input int addr, input logic [127:0] data);
		step();
		ddr3_rd_one_burst = 1'b1;
		ddr3_rd_burst_addr = 23'(addr);
		exp_rd_q.push_back(data);
	endtask

	task automatic end_reads();
		step();
		ddr3_rd_one_burst = 1'b0;
	endtask

	task automatic check_bursts(input int base, input int sa, input int nb);
		for (int b = 0; b < nb; b++)
			read_burst((sa + b) % MEM_BURSTS, exp_burst(base + 8 * b));
		end_reads();
	endtask

	// trigger edge is the next one, first capture two edges later
	task automatic start_fill(input logic [1:0] ftype, output int base, output int sa);
		step();
		{acq_enable1, acq_enable0} = ftype;
		acq_trig = 1'b1;
		base = edge_cnt + 2;
		sa = exp_addr;
		step();
		acq_trig = 1'b0;
	endtask

	task automatic finish_fill(input logic [1:0] ftype, input int sa, input bit do_pop);
		logic [127:0] hdr;
		wait_done();
		hdr = exp_header(ftype, nb_of(ftype), exp_fill, 23'(sa));
		exp_fill = exp_fill + 1'b1;
		exp_addr = (exp_addr + int'(nb_of(ftype))) % MEM_BURSTS;	// wraps with the memory
		@(negedge clk125);
		expect_equal("fill_num", fill_num, exp_fill);
		if (do_pop)
			pop_header(hdr);
	endtask

	task automatic pulse_trig();
		step();
		acq_trig = 1'b1;
		step();
		acq_trig = 1'b0;
	endtask

	// a taken trigger would push its header two edges later
	task automatic check_ignored(input bit en_exp);
		repeat (4) step();
		@(negedge clk125);
		expect_equal("fill_header_fifo_empty", fill_header_fifo_empty, 1);
		expect_equal("fill_num", fill_num, exp_fill);
		expect_equal("acq_enabled", acq_enabled, en_exp);
	endtask

	//////////////////////////////////////////////////
	// stimulus

	initial begin
		arst_n = 1'b0;
		acq_reset = 1'b0;
		channel_tag = TAG;
		num_muon_bursts = 21'd2;
		num_laser_bursts = 21'd3;
		num_ped_bursts = 21'd4;
		initial_fill_num = '0;
		initial_fill_num_wr = 1'b0;
		{acq_enable1, acq_enable0} = 2'b00;
		acq_trig = 1'b0;
		fill_header_fifo_rd_en = 1'b0;
		ddr3_rd_burst_addr = '0;
		ddr3_rd_one_burst = 1'b0;
		repeat (4) @(posedge clk125);
		#1 arst_n = 1'b1;
		@(negedge clk125);
		expect_equal("acq_done", acq_done, 0);
		expect_equal("ddr3_one_burst_rdy", ddr3_one_burst_rdy, 0);
		expect_equal("fill_header_fifo_empty", fill_header_fifo_empty, 1);
		expect_equal("acq_enabled", acq_enabled, 0);

		step();
		initial_fill_num = FIRST_FILL;
		initial_fill_num_wr = 1'b1;
		step();
		initial_fill_num_wr = 1'b0;
		exp_fill = FIRST_FILL;
		exp_addr = 0;
		@(negedge clk125);
		expect_equal("fill_num", fill_num, exp_fill);

		// muon fill
		start_fill(2'b01, base1, sa1);
		finish_fill(2'b01, sa1, 1'b1);
		check_bursts(base1, sa1, 2);

		// laser fill, a retrigger while busy and reads of the muon bursts meanwhile
		start_fill(2'b10, base2, sa2);
		repeat (3) step();
		acq_trig = 1'b1;	// busy, must be dropped
		@(negedge clk125);
		expect_equal("acq_enabled", acq_enabled, 0);
		step();
		acq_trig = 1'b0;
		for (int i = 0; i < 16; i++)
			read_burst((sa1 + i % 2) % MEM_BURSTS, exp_burst(base1 + 8 * (i % 2)));
		end_reads();
		finish_fill(2'b10, sa2, 1'b1);
		check_ignored(1'b1);
		check_bursts(base2, sa2, 3);

		// pedestal fill
		start_fill(2'b11, base3, sa3);
		finish_fill(2'b11, sa3, 1'b1);
		check_bursts(base3, sa3, 4);

		// disabled, then a zero burst count
		step();
		{acq_enable1, acq_enable0} = 2'b00;
		pulse_trig();
		check_ignored(1'b0);
		step();
		num_ped_bursts = '0;
		{acq_enable1, acq_enable0} = 2'b11;
		pulse_trig();
		check_ignored(1'b1);
		step();
		num_ped_bursts = 21'd4;

		// acq_reset drops a waiting header and sends the address back to 0
		start_fill(2'b01, base4, sa4);
		finish_fill(2'b01, sa4, 1'b0);
		@(negedge clk125);
		expect_equal("fill_header_fifo_empty", fill_header_fifo_empty, 0);
		step();
		acq_reset = 1'b1;
		step();
		acq_reset = 1'b0;
		@(negedge clk125);
		expect_equal("fill_header_fifo_empty", fill_header_fifo_empty, 1);
		expect_equal("acq_done", acq_done, 0);
		exp_addr = 0;
		start_fill(2'b10, base5, sa5);
		finish_fill(2'b10, sa5, 1'b1);
		check_bursts(base5, sa5, 3);

		repeat (3) step();
		assert (exp_rd_q.size() == 0 && exp_hdr_q.size() == 0) else begin
			errors++;
			$display("some reads or headers never came back");
		end
		$display("errors: %0d  timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
